//--- Makefile
TOOL       = verilator
TOP        = softmax_tb
FILELIST   = softmax_top.f
LINT_FLAGS = --lint-only --timing --assert -Wall
SIM_FLAGS  = --binary --timing --assert -Wall -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/max_subtract.sv
`timescale 1ns/1ps

module max_subtract (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 emit_en,
  input  softmax_pkg::addr_t   emit_index,
  input  softmax_pkg::vec_t    data,
  input  softmax_pkg::lane_t   max_value,
  output softmax_pkg::result_t result
);
  import softmax_pkg::*;

  vec_t diff;

  // max_value bounds every lane, so only the low side can overflow
  function automatic lane_t sat_sub(lane_t a, lane_t b);
    logic [lane_width:0] d;
    d = {a[lane_width-1], a} - {b[lane_width-1], b};
    if (d[lane_width] && !d[lane_width-1]) begin
      return lane_min;
    end
    return d[lane_width-1:0];
  endfunction

  function automatic logic all_nonpos(vec_t v);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < num_lanes; i++) begin
      if (!v.lane[i][lane_width-1] && v.lane[i] != '0) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      diff.lane[i] = sat_sub(data.lane[i], max_value);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= emit_en;
    end
    if (emit_en) begin
      result.index <= emit_index;
      result.lanes <= diff;
    end
  end

  a_nonpos: assert property (@(posedge clk) disable iff (reset)
    result.valid |-> all_nonpos(result.lanes));

endmodule

//--- design/max_tree.sv
`timescale 1ns/1ps

module max_tree (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear,
  input  logic               in_en,
  input  softmax_pkg::vec_t  in_data,
  output softmax_pkg::lane_t max_value
);
  import softmax_pkg::*;

  vec_t  in_q;
  logic  in_vld;
  lane_t max_01;
  lane_t max_23;
  lane_t word_max;
  lane_t max_q;

  function automatic lane_t lane_max(lane_t a, lane_t b);
    return (a > b) ? a : b;
  endfunction

  // stage 1 holds the scanned word
  always_ff @(posedge clk) begin
    if (reset) begin
      in_vld <= 1'b0;
    end else begin
      in_vld <= in_en;
    end
  end

  always_ff @(posedge clk) begin
    in_q <= in_data;
  end

  assign max_01   = lane_max(in_q.lane[0], in_q.lane[1]);
  assign max_23   = lane_max(in_q.lane[2], in_q.lane[3]);
  assign word_max = lane_max(max_01, max_23);

  // stage 2 folds into the running max
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      max_q <= lane_min;
    end else if (in_vld) begin
      max_q <= lane_max(max_q, word_max);
    end
  end

  assign max_value = max_q;

endmodule

//--- design/softmax_ctrl.sv
`timescale 1ns/1ps

module softmax_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                init,
  input  logic                start,
  input  softmax_pkg::range_t range,
  output softmax_pkg::addr_t  mem_addr,
  output logic                scan_en,
  output softmax_pkg::addr_t  rd_addr,
  output logic                rd_en,
  output logic                clear,
  output logic                emit_en,
  output softmax_pkg::addr_t  emit_index,
  output logic                done
);
  import softmax_pkg::*;

  logic [2:0]              phase;
  range_t                  range_q;
  addr_t                   scan_ptr;
  addr_t                   rd_ptr;
  addr_t                   last_addr;
  logic [settle_width-1:0] settle_cnt;
  logic                    start_ok;
  logic                    last_rd;
  logic                    last_d1;
  logic                    last_d2;

  assign start_ok  = start && (phase == phase_idle);
  assign last_addr = range_q.end_addr - addr_t'(1);

  assign mem_addr = scan_ptr;
  assign scan_en  = (phase == phase_scan);
  assign rd_addr  = rd_ptr;
  assign rd_en    = (phase == phase_replay);
  assign clear    = start_ok;
  assign last_rd  = rd_en && (rd_ptr == last_addr);

  // new range only between runs
  always_ff @(posedge clk) begin
    if (reset) begin
      range_q <= '0;
    end else if (init && phase == phase_idle) begin
      range_q <= range;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= phase_idle;
      scan_ptr   <= '0;
      rd_ptr     <= '0;
      settle_cnt <= '0;
    end else begin
      case (phase)
        phase_idle: begin
          if (start_ok) begin
            phase    <= phase_scan;
            scan_ptr <= range_q.start_addr;
          end
        end
        phase_scan: begin
          if (scan_ptr == last_addr) begin
            phase      <= phase_settle;
            settle_cnt <= '0;
          end else begin
            scan_ptr <= scan_ptr + addr_t'(1);
          end
        end
        // let the max tree fold in the last words
        phase_settle: begin
          if (settle_cnt == settle_width'(settle_cycles - 1)) begin
            phase  <= phase_replay;
            rd_ptr <= range_q.start_addr;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        phase_replay: begin
          if (rd_ptr == last_addr) begin
            phase <= phase_drain;
          end else begin
            rd_ptr <= rd_ptr + addr_t'(1);
          end
        end
        phase_drain: begin
          if (last_d2) begin
            phase <= phase_idle;
          end
        end
        default: phase <= phase_idle;
      endcase
    end
  end

  // emit lines up with the registered buffer read, done trails the last result
  always_ff @(posedge clk) begin
    if (reset) begin
      emit_en <= 1'b0;
      last_d1 <= 1'b0;
      last_d2 <= 1'b0;
      done    <= 1'b0;
    end else begin
      emit_en <= rd_en;
      last_d1 <= last_rd;
      last_d2 <= last_d1;
      done    <= last_d2;
    end
  end

  always_ff @(posedge clk) begin
    emit_index <= rd_ptr - range_q.start_addr;
  end

  a_scan_in_range: assert property (@(posedge clk) disable iff (reset)
    scan_en |-> (mem_addr >= range_q.start_addr) && (mem_addr < range_q.end_addr));

  a_range_order: assert property (@(posedge clk) disable iff (reset)
    start_ok |-> range_q.end_addr > range_q.start_addr);

endmodule

//--- design/softmax_pkg.sv
package softmax_pkg;

  localparam int lane_width    = 16;
  localparam int num_lanes     = 4;
  localparam int addr_width    = 8;
  // cycles from last scan read until the running max is final
  localparam int settle_cycles = 2;
  localparam int settle_width  = 2;

  typedef logic signed [lane_width-1:0] lane_t;
  typedef logic [addr_width-1:0] addr_t;

  // lane 0 sits in the low bits
  typedef struct packed {
    lane_t [num_lanes-1:0] lane;
  } vec_t;

  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } range_t;

  typedef struct packed {
    logic  valid;
    addr_t index;
    vec_t  lanes;
  } result_t;

  localparam lane_t lane_min = {1'b1, {(lane_width-1){1'b0}}};

  // controller phases
  localparam logic [2:0] phase_idle   = 3'd0;
  localparam logic [2:0] phase_scan   = 3'd1;
  localparam logic [2:0] phase_settle = 3'd2;
  localparam logic [2:0] phase_replay = 3'd3;
  localparam logic [2:0] phase_drain  = 3'd4;

endpackage

//--- design/softmax_top.sv
`timescale 1ns/1ps

module softmax_top (
  input  logic                 clk,
  input  logic                 reset,
  input  softmax_pkg::range_t  range,
  input  logic                 init,
  input  logic                 start,
  input  softmax_pkg::vec_t    mem_data,
  output softmax_pkg::addr_t   mem_addr,
  output softmax_pkg::result_t result,
  output logic                 done
);
  import softmax_pkg::*;

  logic  scan_en;
  logic  rd_en;
  addr_t rd_addr;
  logic  clear;
  logic  emit_en;
  addr_t emit_index;
  vec_t  rd_data;
  lane_t max_value;

  softmax_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .start      (start),
    .range      (range),
    .mem_addr   (mem_addr),
    .scan_en    (scan_en),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .clear      (clear),
    .emit_en    (emit_en),
    .emit_index (emit_index),
    .done       (done)
  );

  // scanned words land in the buffer at the memory address
  vector_buffer buf0 (
    .clk     (clk),
    .wr_en   (scan_en),
    .wr_addr (mem_addr),
    .wr_data (mem_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  max_tree tree0 (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .in_en     (scan_en),
    .in_data   (mem_data),
    .max_value (max_value)
  );

  max_subtract sub0 (
    .clk        (clk),
    .reset      (reset),
    .emit_en    (emit_en),
    .emit_index (emit_index),
    .data       (rd_data),
    .max_value  (max_value),
    .result     (result)
  );

endmodule

//--- design/vector_buffer.sv
`timescale 1ns/1ps

module vector_buffer (
  input  logic               clk,
  input  logic               wr_en,
  input  softmax_pkg::addr_t wr_addr,
  input  softmax_pkg::vec_t  wr_data,
  input  logic               rd_en,
  input  softmax_pkg::addr_t rd_addr,
  output softmax_pkg::vec_t  rd_data
);
  import softmax_pkg::*;

  vec_t mem [2**addr_width];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- softmax_top.f
design/softmax_pkg.sv
design/vector_buffer.sv
design/max_tree.sv
design/max_subtract.sv
design/softmax_ctrl.sv
design/softmax_top.sv
verification/softmax_tb.sv

//--- verification/softmax_tb.sv
`timescale 1ns/1ps

module softmax_tb;
  import softmax_pkg::*;

  logic    clk;
  logic    reset;
  range_t  range;
  logic    init;
  logic    start;
  vec_t    mem_data;
  addr_t   mem_addr;
  result_t result;
  logic    done;

  vec_t    mem_image [2**addr_width];
  result_t expected [$];
  int      errors;
  int      cycles;
  int      cycle_limit;

  softmax_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .range    (range),
    .init     (init),
    .start    (start),
    .mem_data (mem_data),
    .mem_addr (mem_addr),
    .result   (result),
    .done     (done)
  );

  // memory answers in the same cycle
  assign mem_data = mem_image[mem_addr];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles, done never arrived", cycles);
    $display("Test failed");
    $finish;
  end

  function automatic lane_t small_lane();
    return lane_t'(int'($urandom_range(0, 4000)) - 2000);
  endfunction

  function automatic vec_t small_word();
    vec_t w;
    for (int l = 0; l < num_lanes; l++) begin
      w.lane[l] = small_lane();
    end
    return w;
  endfunction

  // lane minus max, clipped at the most negative value
  function automatic lane_t expected_lane(lane_t value, lane_t max);
    int diff;
    diff = int'(value) - int'(max);
    if (diff < int'(lane_min)) begin
      diff = int'(lane_min);
    end
    return lane_t'(diff);
  endfunction

  task automatic check_result(string name, result_t exp, result_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("FAIL %s result count: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("FAIL %s scan address: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_quiet(string name, int len);
    repeat (len) begin
      @(negedge clk);
      if (result.valid !== 1'b0 || done !== 1'b0) begin
        $display("%s: result valid or done raised while the engine should be idle", name);
        errors++;
      end
    end
  endtask

  task automatic run_test(string name, addr_t lo, addr_t hi, logic busy_start);
    lane_t   max;
    result_t exp;
    int      n;
    int      count;
    int      quiet;
    n = int'(hi) - int'(lo);
    quiet = busy_start ? 2 * n + settle_cycles + 6 : 2;
    cycle_limit += 2 * n + settle_cycles + 20 + quiet;
    max = lane_min;
    for (int a = lo; a < hi; a++) begin
      for (int l = 0; l < num_lanes; l++) begin
        if (mem_image[a].lane[l] > max) begin
          max = mem_image[a].lane[l];
        end
      end
    end
    expected.delete();
    for (int a = lo; a < hi; a++) begin
      exp.valid = 1'b1;
      exp.index = addr_t'(a - int'(lo));
      for (int l = 0; l < num_lanes; l++) begin
        exp.lanes.lane[l] = expected_lane(mem_image[a].lane[l], max);
      end
      expected.push_back(exp);
    end
    @(posedge clk);
    #1;
    range.start_addr = lo;
    range.end_addr = hi;
    init = 1'b1;
    @(posedge clk);
    #1;
    init = 1'b0;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // scan walks the range one word per cycle
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      check_addr(name, addr_t'(int'(lo) + k), mem_addr);
    end
    if (busy_start) begin
      repeat (2) @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    count = 0;
    forever begin
      @(negedge clk);
      if (done === 1'b1) begin
        break;
      end
      if (result.valid === 1'b1) begin
        if (count < n) begin
          check_result(name, expected[count], result);
        end
        count++;
      end
    end
    check_count(name, addr_t'(n), addr_t'(count));
    expect_quiet(name, quiet);
  endtask

  initial begin
    int lo;
    int n;
    void'($urandom(10));
    errors = 0;
    cycle_limit = 40;
    reset = 1'b1;
    init = 1'b0;
    start = 1'b0;
    range = '0;
    for (int a = 0; a < 2**addr_width; a++) begin
      for (int l = 0; l < num_lanes; l++) begin
        mem_image[a].lane[l] = lane_t'($urandom);
      end
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    expect_quiet("idle after reset", 20);

    for (int t = 0; t < 4; t++) begin
      n = $urandom_range(1, 48);
      lo = $urandom_range(0, 255 - n);
      run_test("random range", addr_t'(lo), addr_t'(lo + n), 1'b0);
    end

    // one full-scale positive lane among most negative ones
    for (int a = 0; a < 8; a++) begin
      mem_image[a] = small_word();
      mem_image[a].lane[a % num_lanes] = lane_min;
    end
    mem_image[5].lane[1] = lane_t'(16'h7fff);
    run_test("saturation", 8'd0, 8'd8, 1'b0);

    for (int p = 0; p < num_lanes; p++) begin
      for (int a = 16; a < 24; a++) begin
        mem_image[a] = small_word();
      end
      mem_image[16 + 2 * p].lane[p] = lane_t'(16'h3000);
      run_test($sformatf("max in lane %0d", p), 8'd16, 8'd24, 1'b0);
    end

    // large first run must not leak into the second
    for (int a = 32; a < 40; a++) begin
      for (int l = 0; l < num_lanes; l++) begin
        mem_image[a].lane[l] = lane_t'(16'h7000);
      end
    end
    for (int a = 64; a < 76; a++) begin
      mem_image[a] = small_word();
    end
    run_test("first of pair", 8'd32, 8'd40, 1'b0);
    run_test("second of pair", 8'd64, 8'd76, 1'b1);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
